// ==== include/int_core_params.svh ====
`ifndef INT_CORE_PARAMS_SVH
`define INT_CORE_PARAMS_SVH

`define XLEN       32
`define REG_COUNT  32
`define REG_ADDR_W 5

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011

`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// sub and sra
`define F7_ALT 7'b0100000

`endif

// ==== hdl/int_core_pkg.sv ====
`include "int_core_params.svh"

package int_core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_inst_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_inst_t;

  // one instruction word with two views
  typedef union packed {
    r_inst_t r;
    i_inst_t i;
  } inst_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

endpackage

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps
`include "int_core_params.svh"

module inst_decoder
  import int_core_pkg::*;
(
  input  logic      inst_valid,
  input  inst_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output logic      use_imm,
  output alu_op_e   alu_op,
  output logic      reg_write
);

  logic legal;

  function automatic alu_op_e select_op(input logic [2:0] funct3, input logic alt);
    alu_op_e op;
    case (funct3)
      `F3_ADD:  op = alt ? alu_sub : alu_add;
      `F3_SLL:  op = alu_sll;
      `F3_SLT:  op = alu_slt;
      `F3_SLTU: op = alu_sltu;
      `F3_XOR:  op = alu_xor;
      `F3_SR:   op = alt ? alu_sra : alu_srl;
      `F3_OR:   op = alu_or;
      `F3_AND:  op = alu_and;
      default:  op = alu_add;
    endcase
    return op;
  endfunction

  // register fields sit in the same place in both views
  assign rs1 = inst.i.rs1;
  assign rs2 = inst.r.rs2;
  assign rd  = inst.r.rd;

  // sign extended I immediate
  assign imm = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};

  always_comb begin
    legal   = 1'b0;
    use_imm = 1'b0;
    alu_op  = alu_add;
    case (inst.r.opcode)
      `OPC_OP: begin
        legal  = 1'b1;
        alu_op = select_op(inst.r.funct3, inst.r.funct7 == `F7_ALT);
      end
      `OPC_OP_IMM: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        // only the shift takes funct7 from imm since addi has no subtract form
        alu_op  = select_op(inst.i.funct3,
                            inst.i.funct3 == `F3_SR && inst.i.imm[11:5] == `F7_ALT);
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // x0 is never marked as written
  assign reg_write = inst_valid && legal && (rd != '0);

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`include "int_core_params.svh"

module register_file
  import int_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      write_en,
  input  reg_addr_t write_addr,
  input  word_t     write_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  // x1 to x31 only
  word_t regs [1:`REG_COUNT-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  // x0 hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // decoder must never schedule a write to x0
  no_x0_write: assert property (@(posedge clock) disable iff (reset)
    !(write_en && write_addr == '0));

endmodule

// ==== hdl/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass
  import int_core_pkg::*;
(
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  logic      ex_reg_write,
  input  reg_addr_t ex_rd,
  input  word_t     ex_result,
  input  logic      wb_reg_write,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  output word_t     op_a,
  output word_t     op_b
);

  // newest producer wins
  function automatic word_t pick(input reg_addr_t src, input word_t rf_data);
    word_t value;
    if (ex_reg_write && ex_rd == src) begin
      value = ex_result;
    end else if (wb_reg_write && wb_rd == src) begin
      value = wb_data;
    end else begin
      value = rf_data;
    end
    return value;
  endfunction

  // no x0 check since x0 is never marked written
  always_comb begin
    op_a = pick(rs1, rs1_data);
    op_b = pick(rs2, rs2_data);
  end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
  import int_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      reg_write,
  input  reg_addr_t rd,
  input  word_t     op_a,
  input  word_t     op_b,
  input  word_t     imm,
  input  logic      use_imm,
  input  alu_op_e   alu_op,
  output logic      ex_reg_write,
  output reg_addr_t ex_rd,
  output word_t     ex_result,
  output logic      wb_reg_write,
  output reg_addr_t wb_rd,
  output word_t     wb_data
);

  word_t   a_q;
  word_t   b_q;
  word_t   imm_q;
  logic    use_imm_q;
  alu_op_e alu_op_q;
  word_t   b_sel;
  logic [4:0] shamt;

  // decode/execute register
  always_ff @(posedge clock) begin
    if (reset) begin
      ex_reg_write <= 1'b0;
    end else begin
      ex_reg_write <= reg_write;
    end
  end

  always_ff @(posedge clock) begin
    ex_rd     <= rd;
    a_q       <= op_a;
    b_q       <= op_b;
    imm_q     <= imm;
    use_imm_q <= use_imm;
    alu_op_q  <= alu_op;
  end

  assign b_sel = use_imm_q ? imm_q : b_q;
  assign shamt = b_sel[4:0];

  always_comb begin
    case (alu_op_q)
      alu_add:  ex_result = a_q + b_sel;
      alu_sub:  ex_result = a_q - b_sel;
      alu_sll:  ex_result = a_q << shamt;
      alu_slt:  ex_result = word_t'($signed(a_q) < $signed(b_sel));
      alu_sltu: ex_result = word_t'(a_q < b_sel);
      alu_xor:  ex_result = a_q ^ b_sel;
      alu_srl:  ex_result = a_q >> shamt;
      alu_sra:  ex_result = word_t'($signed(a_q) >>> shamt);
      alu_or:   ex_result = a_q | b_sel;
      alu_and:  ex_result = a_q & b_sel;
      default:  ex_result = '0;
    endcase
  end

  // execute/write-back register
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
    end else begin
      wb_reg_write <= ex_reg_write;
    end
  end

  always_ff @(posedge clock) begin
    wb_rd   <= ex_rd;
    wb_data <= ex_result;
  end

  // ex_result is forwarded on an rd match so x0 must never be marked written
  ex_rd_not_x0: assert property (@(posedge clock) disable iff (reset)
    ex_reg_write |-> ex_rd != '0);

endmodule

// ==== hdl/int_core_top.sv ====
`timescale 1ns/1ps

module int_core_top
  import int_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      inst_valid,
  input  inst_t     inst,
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_data
);

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  logic      use_imm;
  alu_op_e   alu_op;
  logic      reg_write;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     op_a;
  word_t     op_b;
  logic      ex_reg_write;
  reg_addr_t ex_rd;
  word_t     ex_result;

  inst_decoder decoder (
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .use_imm    (use_imm),
    .alu_op     (alu_op),
    .reg_write  (reg_write)
  );

  register_file regs (
    .clock      (clock),
    .reset      (reset),
    .rs1        (rs1),
    .rs2        (rs2),
    .write_en   (wb_valid),
    .write_addr (wb_rd),
    .write_data (wb_data),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data)
  );

  operand_bypass bypass (
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .ex_reg_write (ex_reg_write),
    .ex_rd        (ex_rd),
    .ex_result    (ex_result),
    .wb_reg_write (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .op_a         (op_a),
    .op_b         (op_b)
  );

  // write-back stage drives the result port and the register file
  execute_stage execute (
    .clock        (clock),
    .reset        (reset),
    .reg_write    (reg_write),
    .rd           (rd),
    .op_a         (op_a),
    .op_b         (op_b),
    .imm          (imm),
    .use_imm      (use_imm),
    .alu_op       (alu_op),
    .ex_reg_write (ex_reg_write),
    .ex_rd        (ex_rd),
    .ex_result    (ex_result),
    .wb_reg_write (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

endmodule

// ==== bench/int_core_tb.sv ====
`timescale 1ns/1ps
`include "int_core_params.svh"

module int_core_tb
  import int_core_pkg::*;
();

  logic      clock;
  logic      reset;
  logic      inst_valid;
  inst_t     inst;
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;

  int unsigned cycle = 0;
  logic [31:0] lcg_state;
  word_t       model_regs [`REG_COUNT];

  // stimulus table
  inst_t       tbl_inst [$];
  int unsigned tbl_idle [$];
  bit          tbl_rand [$];

  // expected write-backs in strobe order
  reg_addr_t   exp_rd [$];
  word_t       exp_data [$];
  int unsigned exp_due [$];

  int_core_top UUT (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic inst_t r_type(input logic [6:0] funct7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] funct3,
                                   input reg_addr_t rd);
    inst_t word;
    word.r = {funct7, rs2, rs1, funct3, rd, `OPC_OP};
    return word;
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] funct3, input reg_addr_t rd);
    inst_t word;
    word.i = {imm, rs1, funct3, rd, `OPC_OP_IMM};
    return word;
  endfunction

  task automatic add_entry(input inst_t word, input int unsigned idle, input bit rnd);
    tbl_inst.push_back(word);
    tbl_idle.push_back(idle);
    tbl_rand.push_back(rnd);
  endtask

  task automatic report_error(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  // architectural model run at strobe time
  task automatic run_model(input inst_t word, input int unsigned strobe);
    word_t a;
    word_t b;
    word_t r;
    logic  alt;
    logic  legal;
    a     = model_regs[word.r.rs1];
    b     = model_regs[word.r.rs2];
    alt   = word.r.funct7 == `F7_ALT;
    legal = word.r.opcode == `OPC_OP;
    if (word.i.opcode == `OPC_OP_IMM) begin
      b     = {{20{word.i.imm[11]}}, word.i.imm};
      alt   = word.i.funct3 == `F3_SR && word.i.imm[11:5] == `F7_ALT;
      legal = 1'b1;
    end
    case (word.r.funct3)
      `F3_ADD:  r = alt ? a - b : a + b;
      `F3_SLL:  r = a << b[4:0];
      `F3_SLT:  r = {31'b0, $signed(a) < $signed(b)};
      `F3_SLTU: r = {31'b0, a < b};
      `F3_XOR:  r = a ^ b;
      `F3_SR: begin
        if (alt)
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      `F3_OR:   r = a | b;
      default:  r = a & b;
    endcase
    if (legal && word.r.rd != '0) begin
      model_regs[word.r.rd] = r;
      exp_rd.push_back(word.r.rd);
      exp_data.push_back(r);
      exp_due.push_back(strobe + 2);
    end
  endtask

  task automatic check_wb(input reg_addr_t rd, input word_t data);
    if (exp_due[0] != cycle) begin
      report_error($sformatf("write-back of x%0d in cycle %0d, due in cycle %0d",
                             rd, cycle, exp_due[0]));
    end else if (rd != exp_rd[0] || data != exp_data[0]) begin
      report_error($sformatf("write-back x%0d = %h, expected x%0d = %h",
                             rd, data, exp_rd[0], exp_data[0]));
    end else begin
      void'(exp_rd.pop_front());
      void'(exp_data.pop_front());
      void'(exp_due.pop_front());
    end
  endtask

  task automatic check_idle();
    if (wb_valid && exp_rd.size() == 0)
      report_error($sformatf("unexpected write-back of x%0d", wb_rd));
    else if (!wb_valid && exp_rd.size() != 0 && exp_due[0] <= cycle)
      report_error($sformatf("write-back of x%0d due in cycle %0d never came",
                             exp_rd[0], exp_due[0]));
  endtask

  // outputs are stable at the falling edge
  task automatic next_cycle();
    @(negedge clock);
    check_idle();
    if (wb_valid && exp_rd.size() != 0)
      check_wb(wb_rd, wb_data);
  endtask

  task automatic build_table();
    add_entry(i_type(12'd5, 0, `F3_ADD, 1), 3, 0);
    add_entry(i_type(12'hffd, 0, `F3_ADD, 2), 2, 0);
    add_entry(i_type(12'h800, 0, `F3_ADD, 3), 1, 0);
    // x4 in execute and write-back at once where the newer value wins
    add_entry(i_type(12'd1, 1, `F3_ADD, 4), 0, 0);
    add_entry(i_type(12'd2, 4, `F3_ADD, 4), 0, 0);
    add_entry(r_type(7'd0, 4, 4, `F3_ADD, 5), 0, 0);
    add_entry(r_type(`F7_ALT, 4, 5, `F3_ADD, 6), 1, 0);
    add_entry(r_type(7'd0, 5, 6, `F3_ADD, 7), 0, 0);
    // random operands
    add_entry(i_type(12'd0, 0, `F3_ADD, 10), 0, 1);
    add_entry(i_type(12'd20, 10, `F3_SLL, 10), 0, 0);
    add_entry(i_type(12'd0, 10, `F3_XOR, 10), 0, 1);
    add_entry(i_type(12'd0, 0, `F3_ADD, 11), 0, 1);
    add_entry(i_type(12'd13, 11, `F3_SLL, 11), 1, 0);
    add_entry(i_type(12'd0, 11, `F3_OR, 11), 2, 1);
    add_entry(r_type(7'd0, 11, 10, `F3_ADD, 12), 0, 0);
    add_entry(r_type(`F7_ALT, 11, 10, `F3_ADD, 13), 1, 0);
    add_entry(r_type(7'd0, 11, 10, `F3_SLL, 14), 0, 0);
    add_entry(r_type(7'd0, 11, 10, `F3_SLT, 15), 2, 0);
    add_entry(r_type(7'd0, 11, 10, `F3_SLTU, 16), 0, 0);
    add_entry(r_type(7'd0, 11, 10, `F3_XOR, 17), 3, 0);
    add_entry(r_type(7'd0, 11, 10, `F3_SR, 18), 0, 0);
    add_entry(r_type(`F7_ALT, 11, 10, `F3_SR, 19), 1, 0);
    add_entry(r_type(7'd0, 11, 10, `F3_OR, 20), 0, 0);
    add_entry(r_type(7'd0, 11, 10, `F3_AND, 21), 0, 0);
    add_entry(r_type(7'd0, 1, 2, `F3_SLT, 22), 0, 0);
    add_entry(r_type(7'd0, 1, 2, `F3_SLTU, 23), 2, 0);
    // immediate group
    add_entry(i_type(12'hfff, 2, `F3_SLTU, 24), 0, 0);
    add_entry(i_type(12'hffe, 2, `F3_SLT, 25), 1, 0);
    add_entry(i_type(12'd0, 10, `F3_XOR, 26), 0, 1);
    add_entry(i_type(12'd0, 10, `F3_OR, 27), 2, 1);
    add_entry(i_type(12'd0, 11, `F3_AND, 28), 0, 1);
    add_entry(i_type(12'd0, 11, `F3_ADD, 29), 0, 1);
    add_entry(i_type(12'd7, 10, `F3_SLL, 30), 3, 0);
    add_entry(i_type(12'd9, 3, `F3_SR, 31), 0, 0);
    add_entry(i_type(12'h401, 2, `F3_SR, 9), 0, 0);
    add_entry(i_type(12'h41f, 3, `F3_SR, 8), 1, 0);
    // x0 targets and unsupported opcodes write nothing
    add_entry(r_type(7'd0, 2, 1, `F3_ADD, 0), 0, 0);
    add_entry(i_type(12'd5, 1, `F3_ADD, 0), 0, 0);
    add_entry(r_type(7'd0, 0, 1, `F3_OR, 7), 0, 0);
    add_entry(inst_t'(32'h0000_0073), 1, 0);
    add_entry(inst_t'(32'h1234_52b7), 0, 0);
    add_entry(r_type(7'd0, 0, 5, `F3_ADD, 4), 0, 0);
    add_entry(r_type(7'd0, 0, 0, `F3_ADD, 6), 3, 0);
  endtask

  initial begin
    int unsigned timeout;
    inst_t       cur;
    logic [31:0] rnd;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    lcg_state  = 32'd33;
    for (int k = 0; k < `REG_COUNT; k++)
      model_regs[k] = '0;
    build_table();
    timeout = tbl_inst.size() + 40;
    foreach (tbl_idle[k])
      timeout += tbl_idle[k];
    fork
      begin
        #(timeout * 4);
        $display("TEST FAIL");
        $fatal(1, "simulation timed out after %0d cycles", timeout);
      end
    join_none
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int k = 0; k < tbl_inst.size(); k++) begin
      cur = tbl_inst[k];
      if (tbl_rand[k]) begin
        rnd = lcg_next();
        cur.i.imm = rnd[27:16];
      end
      next_cycle();
      inst       = cur;
      inst_valid = 1'b1;
      run_model(cur, cycle);
      repeat (tbl_idle[k]) begin
        next_cycle();
        inst_valid = 1'b0;
      end
    end
    next_cycle();
    inst_valid = 1'b0;
    while (exp_rd.size() != 0)
      next_cycle();
    // a few quiet cycles to catch stray write-backs
    repeat (3)
      next_cycle();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/int_core_pkg.sv
hdl/inst_decoder.sv
hdl/register_file.sv
hdl/operand_bypass.sv
hdl/execute_stage.sv
hdl/int_core_top.sv
bench/int_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the integer core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module int_core_tb --Mdir obj_dir -o int_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/int_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
